/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ternaryLayerTb
FILELIST = ternaryLayer.f
OBJDIR   = obj_dir
SIMFLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

/* common/tnnPkg.sv */
/*
 * Shared types and constants for the ternary neural layer.
 * Every RTL module imports this package for its trit, mode and configuration types.
 */
package tnnPkg;

    // ============================================================
    // element and activation types
    // ============================================================
    typedef logic signed [1:0] trit_t;          // -1, 0 or +1, the code 2'b10 is never used
    typedef logic signed [1:0] act_t;           // same encoding as trit_t
    typedef logic signed [15:0] threshold_t;

    localparam act_t actNeg = 2'b11;
    localparam act_t actZero = 2'b00;
    localparam act_t actPos = 2'b01;

    // ============================================================
    // weight mode, the meaning of a {0, 1} weight bit
    // ============================================================
    typedef logic [1:0] weightMode_t;

    localparam weightMode_t modeZero = 2'b00;      // {0, 0}
    localparam weightMode_t modeZeroPos = 2'b01;   // {0, +1}
    localparam weightMode_t modePosNeg = 2'b10;    // {+1, -1}
    localparam weightMode_t modeZeroNeg = 2'b11;   // {0, -1}

    // ============================================================
    // configuration write
    // ============================================================
    typedef logic [1:0] cfgTarget_t;

    localparam cfgTarget_t cfgWeights = 2'd0;
    localparam cfgTarget_t cfgMode = 2'd1;
    localparam cfgTarget_t cfgThreshold = 2'd2;

    localparam int maxVecLen = 64;

    typedef struct packed {
        cfgTarget_t target;
        logic [7:0] neuron;                     // only used by weight writes
        logic [maxVecLen-1:0] data;             // row, mode or threshold in the low bits
    } cfgWrite_t;

    // number of register stages implied by a tree pipeline mask
    function automatic int unsigned countPipeStages(input int unsigned mask);
        int unsigned stages = 0;
        for (int i = 0; i < 32; i++) begin
            stages += mask[i];
        end
        return stages;
    endfunction

endpackage

/* dotTree/dotTree.sv */
/*
 * Recursive ternary dot product of one weight row with one trit vector.
 * Each tree level may carry a register, selected by pipeMask (bit 0 is this node).
 * Latency is the number of set bits in pipeMask, zero means purely combinational.
 */
`timescale 1ns/1ps

module dotTree import tnnPkg::*; #(
    parameter int vecLen = 16,
    parameter int unsigned pipeMask = 5'b00101,
    localparam int sumW = $clog2(vecLen) + 2
) (
    input  logic clk,
    input  logic arstN,
    input  weightMode_t mode,
    input  logic [vecLen-1:0] weights,
    input  logic [2*vecLen-1:0] data,
    output logic signed [sumW-1:0] sum
);

    // maps one weight bit and one trit through the layer mode
    function automatic trit_t tritProduct(input weightMode_t m, input logic w, input trit_t d);
        trit_t p = '0;
        case (m)
            modeZero: p = '0;
            modeZeroPos: p = w ? d : trit_t'(0);
            modePosNeg: p = w ? -d : d;
            modeZeroNeg: p = w ? -d : trit_t'(0);
        endcase
        return p;
    endfunction

    if (vecLen == 1) begin : leaf
        // a leaf takes every remaining stage so that uneven branches stay aligned
        localparam int unsigned leafStages = countPipeStages(pipeMask);

        trit_t product;

        assign product = tritProduct(mode, weights[0], trit_t'(data[1:0]));

        if (leafStages == 0) begin : comb
            assign sum = product;
        end else begin : piped
            trit_t stage [leafStages];

            always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                    for (int s = 0; s < leafStages; s++) begin
                        stage[s] <= '0;
                    end
                end else begin
                    stage[0] <= product;
                    for (int s = 1; s < leafStages; s++) begin
                        stage[s] <= stage[s-1];
                    end
                end
            end

            assign sum = stage[leafStages-1];
        end
    end else begin : node
        localparam int nLo = (1 << $clog2(vecLen)) / 2;     // power of two half
        localparam int nHi = vecLen - nLo;
        localparam int loW = $clog2(nLo) + 2;
        localparam int hiW = $clog2(nHi) + 2;

        logic signed [loW-1:0] loSum;
        logic signed [hiW-1:0] hiSum;
        logic signed [sumW-1:0] sumComb;

        dotTree #(.vecLen(nLo), .pipeMask(pipeMask >> 1)) u_lo (
            .clk(clk),
            .arstN(arstN),
            .mode(mode),
            .weights(weights[0 +: nLo]),
            .data(data[0 +: 2*nLo]),
            .sum(loSum)
        );

        dotTree #(.vecLen(nHi), .pipeMask(pipeMask >> 1)) u_hi (
            .clk(clk),
            .arstN(arstN),
            .mode(mode),
            .weights(weights[nLo +: nHi]),
            .data(data[2*nLo +: 2*nHi]),
            .sum(hiSum)
        );

        assign sumComb = loSum + hiSum;                     // both children sign-extend

        if (pipeMask[0]) begin : piped
            logic signed [sumW-1:0] sumReg;

            always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                    sumReg <= '0;
                end else begin
                    sumReg <= sumComb;
                end
            end

            assign sum = sumReg;
        end else begin : comb
            assign sum = sumComb;
        end
    end

endmodule

/* rtl/neuronArray.sv */
/*
 * One dotTree per neuron plus the valid delay line that tracks the tree latency.
 * Sums and ternary activations are registered together, so results leave
 * exactly P+1 cycles after inValid, P being the set bits of pipeMask.
 */
`timescale 1ns/1ps

module neuronArray import tnnPkg::*; #(
    parameter int vecLen = 16,
    parameter int numNeurons = 4,
    parameter int unsigned pipeMask = 5'b00101,
    localparam int sumW = $clog2(vecLen) + 2
) (
    input  logic clk,
    input  logic arstN,
    input  logic inValid,
    input  logic [2*vecLen-1:0] inData,
    input  logic [numNeurons*vecLen-1:0] weightRows,
    input  weightMode_t mode,
    input  threshold_t threshold,
    output logic outValid,
    output logic [numNeurons-1:0][sumW-1:0] outSum,
    output act_t [numNeurons-1:0] outAct
);

    localparam int unsigned treeStages = countPipeStages(pipeMask);

    logic validDly;
    logic signed [sumW-1:0] treeSum [numNeurons];

    // +1 above the threshold, -1 below its negative, 0 in the band between
    function automatic act_t activate(input logic signed [sumW-1:0] s, input threshold_t thr);
        logic signed [16:0] sumWide;
        logic signed [16:0] thrWide;
        act_t a;
        sumWide = s;
        thrWide = thr;                          // 17 bits so that -thr never overflows
        if (sumWide > thrWide) begin
            a = actPos;
        end else if (sumWide < -thrWide) begin
            a = actNeg;
        end else begin
            a = actZero;
        end
        return a;
    endfunction

    // ============================================================
    // dot-product trees
    // ============================================================
    for (genvar n = 0; n < numNeurons; n++) begin : neuron
        dotTree #(.vecLen(vecLen), .pipeMask(pipeMask)) u_tree (
            .clk(clk),
            .arstN(arstN),
            .mode(mode),
            .weights(weightRows[n*vecLen +: vecLen]),
            .data(inData),
            .sum(treeSum[n])
        );
    end

    // ============================================================
    // valid delay line, one stage per tree register level
    // ============================================================
    if (treeStages == 0) begin : noValidLine
        assign validDly = inValid;
    end else begin : validLine
        logic [treeStages-1:0] validPipe;

        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                validPipe <= '0;
            end else begin
                validPipe <= treeStages'({validPipe, inValid});   // shift toward the msb
            end
        end

        assign validDly = validPipe[treeStages-1];
    end

    // ============================================================
    // output register
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outSum <= '0;
            outAct <= '0;
        end else begin
            outValid <= validDly;
            if (validDly) begin                 // results hold between pulses
                for (int n = 0; n < numNeurons; n++) begin
                    outSum[n] <= treeSum[n];
                    outAct[n] <= activate(treeSum[n], threshold);
                end
            end
        end
    end

endmodule

/* rtl/ternaryLayer.sv */
/*
 * Top level of the ternary layer: configuration store feeding the neuron array.
 * Results follow each inValid strobe by P+1 cycles, 3 with the default pipeMask.
 */
`timescale 1ns/1ps

module ternaryLayer import tnnPkg::*; #(
    parameter int vecLen = 16,
    parameter int numNeurons = 4,
    parameter int unsigned pipeMask = 5'b00101,     // root is bit 0
    localparam int sumW = $clog2(vecLen) + 2
) (
    input  logic clk,
    input  logic arstN,
    input  logic cfgValid,
    input  cfgWrite_t cfg,
    input  logic inValid,
    input  logic [2*vecLen-1:0] inData,
    output logic outValid,
    output logic [numNeurons-1:0][sumW-1:0] outSum,
    output act_t [numNeurons-1:0] outAct
);

    logic [numNeurons*vecLen-1:0] weightRows;
    weightMode_t mode;
    threshold_t threshold;

    weightBank #(
        .vecLen(vecLen),
        .numNeurons(numNeurons)
    ) u_weightBank (
        .clk(clk),
        .arstN(arstN),
        .cfgValid(cfgValid),
        .cfg(cfg),
        .weightRows(weightRows),
        .mode(mode),
        .threshold(threshold)
    );

    neuronArray #(
        .vecLen(vecLen),
        .numNeurons(numNeurons),
        .pipeMask(pipeMask)
    ) u_neuronArray (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .inData(inData),
        .weightRows(weightRows),
        .mode(mode),
        .threshold(threshold),
        .outValid(outValid),
        .outSum(outSum),
        .outAct(outAct)
    );

endmodule

/* rtl/weightBank.sv */
/*
 * Configuration store of the layer: one weight row per neuron, the weight mode
 * and the activation threshold. A cfgValid strobe writes one of them at that edge.
 */
`timescale 1ns/1ps

module weightBank import tnnPkg::*; #(
    parameter int vecLen = 16,
    parameter int numNeurons = 4
) (
    input  logic clk,
    input  logic arstN,
    input  logic cfgValid,
    input  cfgWrite_t cfg,
    output logic [numNeurons*vecLen-1:0] weightRows,
    output weightMode_t mode,
    output threshold_t threshold
);

    // ============================================================
    // elaboration checks
    // ============================================================
    if (vecLen > maxVecLen) begin : badVecLen
        $error("vecLen %0d is wider than the configuration data field", vecLen);
    end

    if (numNeurons > 256) begin : badNeuronCount
        $error("numNeurons %0d cannot be addressed by an 8-bit index", numNeurons);
    end

    // ============================================================
    // write decode
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            weightRows <= '0;
            mode <= modeZero;
            threshold <= '0;
        end else if (cfgValid) begin
            case (cfg.target)
                cfgWeights: begin
                    // an index past the last neuron matches no row and is dropped
                    for (int n = 0; n < numNeurons; n++) begin
                        if (cfg.neuron == 8'(n)) begin
                            weightRows[n*vecLen +: vecLen] <= cfg.data[vecLen-1:0];
                        end
                    end
                end
                cfgMode: begin
                    mode <= weightMode_t'(cfg.data[1:0]);
                end
                cfgThreshold: begin
                    threshold <= threshold_t'(cfg.data[15:0]);
                end
                default: begin
                    // reserved target code, nothing is written
                end
            endcase
        end
    end

endmodule

/* ternaryLayer.f */
common/tnnPkg.sv
dotTree/dotTree.sv
rtl/weightBank.sv
rtl/neuronArray.sv
rtl/ternaryLayer.sv
testbench/ternaryLayer_chk.sv
testbench/ternaryLayerTb.sv

/* testbench/ternaryLayerTb.sv */
/*
 * Self-checking testbench for ternaryLayer. Drives configuration writes and
 * LFSR vectors, predicts each result with its own model and checks every outValid.
 */
`timescale 1ns/1ps

module ternaryLayerTb import tnnPkg::*; ();

    localparam int vecLen = 16;
    localparam int numNeurons = 4;
    localparam int sumW = $clog2(vecLen) + 2;
    localparam int latency = 3;                 // two tree registers and the output register
    localparam int clkPeriod = 100;
    localparam int drainCycles = latency + 8;

    // cycle budget of each test, a config write or a single vector takes two cycles
    localparam int uniformCycles = 4 * (2 + drainCycles + 2 * (2 * numNeurons + 6 + drainCycles));
    localparam int randomCycles = 4 * (4 + 2 * numNeurons + 16 + drainCycles);
    localparam int burstCycles = 2 + 21 + drainCycles;
    localparam int thresholdCycles = 2 + 2 * numNeurons + 3 * (16 + 2 * drainCycles);
    localparam int rowCycles = 4 + 2 * numNeurons + 4 + 2 * (10 + drainCycles);
    localparam int resetCycles = 3 * drainCycles + 8 + 6;
    localparam int testCycles = 2 + uniformCycles + randomCycles + burstCycles
                              + thresholdCycles + rowCycles + resetCycles;

    typedef struct packed {
        logic [numNeurons-1:0][31:0] sums;
        logic [numNeurons-1:0][31:0] acts;
        logic [31:0] due;                       // cycle in which outValid must be seen
    } result_t;

    logic clk;
    logic arstN;
    logic cfgValid;
    cfgWrite_t cfg;
    logic inValid;
    logic [2*vecLen-1:0] inData;
    logic outValid;
    logic [numNeurons-1:0][sumW-1:0] outSum;
    act_t [numNeurons-1:0] outAct;

    logic [vecLen-1:0] rowModel [numNeurons];
    weightMode_t modeModel;
    int thrModel;
    result_t expectQ [$];
    logic [31:0] lfsrState = 32'd99646;
    int cycleCount = 0;
    int errorCount = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    string testName = "startup";

    ternaryLayer u_dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // ============================================================
    // reference model and stimulus helpers
    // ============================================================
    function automatic int weightValue(input weightMode_t m, input logic w);
        case (m)
            modeZeroPos: return w ? 1 : 0;
            modePosNeg: return w ? -1 : 1;
            modeZeroNeg: return w ? -1 : 0;
            default: return 0;
        endcase
    endfunction

    function automatic result_t referenceResult(input logic [2*vecLen-1:0] vec, input int due);
        result_t r;
        int s;
        r.due = due;
        for (int n = 0; n < numNeurons; n++) begin
            s = 0;
            for (int i = 0; i < vecLen; i++) begin
                s += weightValue(modeModel, rowModel[n][i]) * int'($signed(vec[2*i +: 2]));
            end
            r.sums[n] = s;
            r.acts[n] = (s > thrModel) ? 1 : ((s < -thrModel) ? -1 : 0);
        end
        return r;
    endfunction

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);    // taps 32, 22, 2, 1
    endfunction

    function automatic logic [2*vecLen-1:0] uniformVector(input int t);
        logic [2*vecLen-1:0] v;
        for (int i = 0; i < vecLen; i++) begin
            v[2*i +: 2] = 2'(t);
        end
        return v;
    endfunction

    task automatic drawBits(input int count, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value[i] = lfsrState[0];
        end
    endtask

    task automatic randomVector(output logic [2*vecLen-1:0] vec);
        logic [63:0] bits;
        for (int i = 0; i < vecLen; i++) begin
            drawBits(2, bits);
            while (bits[1:0] == 2'b10) begin    // -2 is not a legal trit, draw again
                drawBits(2, bits);
            end
            vec[2*i +: 2] = bits[1:0];
        end
    endtask

    task automatic clearModel();
        for (int n = 0; n < numNeurons; n++) begin
            rowModel[n] = '0;
        end
        modeModel = modeZero;
        thrModel = 0;
    endtask

    task automatic writeConfig(input cfgTarget_t target, input int neuron, input logic [63:0] data);
        @(posedge clk);
        cfgValid <= 1'b1;
        cfg.target <= target;
        cfg.neuron <= 8'(neuron);
        cfg.data <= data;
        if (target == cfgWeights && neuron >= 0 && neuron < numNeurons) begin
            rowModel[neuron] = data[vecLen-1:0];
        end else if (target == cfgMode) begin
            modeModel = data[1:0];
        end else if (target == cfgThreshold) begin
            thrModel = int'($signed(data[15:0]));
        end
        @(posedge clk);
        cfgValid <= 1'b0;
    endtask

    task automatic sendVector(input logic [2*vecLen-1:0] vec);
        @(posedge clk);
        inValid <= 1'b1;
        inData <= vec;
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    // ============================================================
    // reporting
    // ============================================================
    task automatic reportMismatch(input string what, input int expected, input int actual);
        $display("ERROR %s: %s expected %0d actual %0d", testName, what, expected, actual);
        errorCount++;
        testErrors++;
    endtask

    task automatic reportProblem(input string what);
        $display("%s: %s", testName, what);
        errorCount++;
        testErrors++;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expectQ.size() != 0 && waited < drainCycles) begin
            @(negedge clk);
            waited++;
        end
        assert (expectQ.size() == 0) else begin
            reportProblem($sformatf("%0d results never arrived", expectQ.size()));
            expectQ.delete();
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        waitDrain();
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", testName, testErrors);
        end
    endtask

    // ============================================================
    // expectation queue and compare
    // ============================================================
    always @(negedge clk) begin
        if (arstN && inValid) begin
            expectQ.push_back(referenceResult(inData, cycleCount + latency));
        end
    end

    always @(negedge clk) begin : compareResults
        result_t head;
        int expVal;
        int gotVal;
        if (!arstN) begin
            assert (!outValid) else reportProblem("outValid is high during reset");
        end else if (outValid) begin
            assert (expectQ.size() != 0) else reportProblem("outValid pulsed with no vector in flight");
            if (expectQ.size() != 0) begin
                head = expectQ.pop_front();
                assert (int'(head.due) == cycleCount)
                    else reportMismatch("result cycle", int'(head.due), cycleCount);
                for (int n = 0; n < numNeurons; n++) begin
                    expVal = int'($signed(head.sums[n]));
                    gotVal = int'($signed(outSum[n]));
                    assert (expVal == gotVal)
                        else reportMismatch($sformatf("sum of neuron %0d", n), expVal, gotVal);
                    expVal = int'($signed(head.acts[n]));
                    gotVal = int'(outAct[n]);
                    assert (expVal == gotVal)
                        else reportMismatch($sformatf("act of neuron %0d", n), expVal, gotVal);
                end
            end
        end else if (expectQ.size() != 0) begin
            assert (int'(expectQ[0].due) > cycleCount) else begin
                reportProblem("outValid is missing for a vector that was due");
                void'(expectQ.pop_front());
            end
        end
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin : mainSequence
        logic [2*vecLen-1:0] vec;
        logic [63:0] bits;
        int thresholds [3] = '{0, 5, vecLen + 4};
        logic [vecLen-1:0] rowPatterns [numNeurons] = '{16'h0000, 16'hFFFF, 16'h00FF, 16'hA5C3};
        clk = 1'b0;
        arstN = 1'b0;
        cfgValid = 1'b0;
        cfg = '0;
        inValid = 1'b0;
        inData = '0;
        clearModel();
        repeat (2) @(posedge clk);
        arstN <= 1'b1;

        startTest("uniformModes");
        for (int m = 0; m < 4; m++) begin
            writeConfig(cfgMode, 0, 64'(m));
            for (int w = 0; w < 2; w++) begin
                waitDrain();
                for (int n = 0; n < numNeurons; n++) begin
                    writeConfig(cfgWeights, n, (w != 0) ? {64{1'b1}} : 64'd0);
                end
                for (int t = -1; t <= 1; t++) begin
                    sendVector(uniformVector(t));
                end
            end
            waitDrain();
        end
        finishTest();

        startTest("randomModes");
        for (int m = 0; m < 4; m++) begin
            writeConfig(cfgMode, 0, 64'(m));
            drawBits(3, bits);
            writeConfig(cfgThreshold, 0, bits);
            for (int n = 0; n < numNeurons; n++) begin
                drawBits(vecLen, bits);
                writeConfig(cfgWeights, n, bits);
            end
            for (int v = 0; v < 8; v++) begin
                randomVector(vec);
                sendVector(vec);
            end
            waitDrain();
        end
        finishTest();

        startTest("backToBack");
        writeConfig(cfgMode, 0, 64'(modePosNeg));
        for (int v = 0; v < 20; v++) begin
            randomVector(vec);
            @(posedge clk);
            inValid <= 1'b1;
            inData <= vec;
        end
        @(posedge clk);
        inValid <= 1'b0;
        finishTest();

        startTest("thresholds");
        writeConfig(cfgMode, 0, 64'(modeZeroPos));
        for (int n = 0; n < numNeurons; n++) begin
            writeConfig(cfgWeights, n, {64{1'b1}});
        end
        for (int k = 0; k < 3; k++) begin
            waitDrain();
            writeConfig(cfgThreshold, 0, 64'(thresholds[k]));
            for (int t = -1; t <= 1; t++) begin
                sendVector(uniformVector(t));
            end
            for (int v = 0; v < 4; v++) begin
                randomVector(vec);
                sendVector(vec);
            end
        end
        finishTest();

        startTest("perNeuronRows");
        writeConfig(cfgMode, 0, 64'(modePosNeg));
        writeConfig(cfgThreshold, 0, 64'd3);
        for (int n = 0; n < numNeurons; n++) begin
            writeConfig(cfgWeights, n, 64'(rowPatterns[n]));
        end
        for (int r = 0; r < 2; r++) begin
            for (int v = 0; v < 4; v++) begin
                randomVector(vec);
                sendVector(vec);
            end
            sendVector(uniformVector(1));
            waitDrain();
            if (r == 0) begin                   // neither index names a neuron
                drawBits(vecLen, bits);
                writeConfig(cfgWeights, numNeurons, bits);
                writeConfig(cfgWeights, 200, ~bits);
            end
        end
        finishTest();

        startTest("resetBehavior");
        waitDrain();
        @(posedge clk);
        arstN <= 1'b0;
        clearModel();
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            assert (!outValid) else reportProblem("outValid rose after reset before any strobe");
        end
        for (int v = 0; v < 3; v++) begin
            randomVector(vec);
            sendVector(vec);
        end
        finishTest();

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((testCycles + 50) * clkPeriod);
        $display("watchdog expired in test %s, the run did not finish in time", testName);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* testbench/ternaryLayer_chk.sv */
/*
 * Assertion checker bound into ternaryLayer. Watches result timing against
 * inValid, outValid while reset is held and the activation encoding.
 */
`timescale 1ns/1ps

module ternaryLayer_chk import tnnPkg::*; #(
    parameter int numNeurons = 4,
    parameter int unsigned pipeMask = 5'b00101
) (
    input  logic clk,
    input  logic arstN,
    input  logic inValid,
    input  logic outValid,
    input  act_t [numNeurons-1:0] outAct
);

    function automatic int setBits(input int unsigned mask);
        int count;
        count = 0;
        for (int i = 0; i < 32; i++) begin
            count += int'(mask[i]);
        end
        return count;
    endfunction

    localparam int latency = setBits(pipeMask) + 1;   // tree registers plus the output stage

    // ============================================================
    // properties
    // ============================================================
    resultTiming: assert property (@(posedge clk) disable iff (!arstN)
        outValid == $past(inValid, latency))
        else $error("outValid does not follow inValid by %0d cycles", latency);

    resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid is high while reset is asserted");

    for (genvar n = 0; n < numNeurons; n++) begin : actCode
        legalAct: assert property (@(posedge clk) disable iff (!arstN) outAct[n] != 2'b10)
            else $error("neuron %0d drives the unused activation code", n);
    end

endmodule

bind ternaryLayer ternaryLayer_chk #(
    .numNeurons(numNeurons),
    .pipeMask(pipeMask)
) u_chk (
    .clk(clk),
    .arstN(arstN),
    .inValid(inValid),
    .outValid(outValid),
    .outAct(outAct)
);
